//--- hw/ps2_kbd_pkg.sv
// ------------------------------------------------------------
// PS/2 keyboard package: widths, frame constants, the key
// code table, the prefix FSM states and the stage link structs
// ------------------------------------------------------------
package ps2_kbd_pkg;

  // Number of tracked keys
  localparam int NUM_KEYS = 20;

  // Bits in one PS/2 frame: start, 8 data, parity, stop
  localparam int FRAME_BITS = 11;

  // PS/2 clock inactivity before a partial frame is dropped
  localparam int FRAME_GAP_CYCLES = 2048;

  // One received data byte
  typedef logic [7:0] scan_byte_t;

  // Index of a tracked key
  typedef logic [4:0] key_idx_t;

  // One bit per key, bit 0 is Q, bits 16..19 are the arrows
  typedef logic [NUM_KEYS-1:0] key_vec_t;

  // Frame bit counter, counts 0..FRAME_BITS-1
  typedef logic [3:0] bit_cnt_t;

  // Idle gap counter in system clock cycles
  typedef logic [$clog2(FRAME_GAP_CYCLES)-1:0] gap_cnt_t;

  // Prefix bytes of Scan Code Set 2
  localparam scan_byte_t CODE_EXT   = 8'hE0;
  localparam scan_byte_t CODE_BREAK = 8'hF0;

  // Set 2 codes in key vector bit order
  localparam scan_byte_t KEY_CODES [NUM_KEYS] = '{
    8'h15, // Q
    8'h1D, // W
    8'h24, // E
    8'h2D, // R
    8'h2C, // T
    8'h35, // Y
    8'h3C, // U
    8'h43, // I
    8'h44, // O
    8'h4D, // P
    8'h1C, // A
    8'h1B, // S
    8'h23, // D
    8'h2B, // F
    8'h34, // G
    8'h33, // H
    8'h6B, // LEFT
    8'h74, // RIGHT
    8'h75, // UP
    8'h72  // DOWN
  };

  // Keys that only count after an E0 prefix (the four arrows)
  localparam key_vec_t KEY_IS_EXT = 20'hF_0000;

  // Decoder prefix FSM
  typedef enum logic [1:0] {
    PFX_MAKE,
    PFX_BREAK,
    PFX_EXT_MAKE,
    PFX_EXT_BREAK
  } prefix_state_t;

  // Frame receiver to decoder link
  typedef struct packed {
    logic       valid;
    scan_byte_t data;
  } byte_strobe_t;

  // Decoder to tracker link
  typedef struct packed {
    logic     valid;
    key_idx_t key;
    // 1 for a press, 0 for a release
    logic     make;
  } key_event_t;

endpackage

//--- hw/ps2_line_sync.sv
// ------------------------------------------------------------
// PS/2 line synchronizer: brings clock and data into CLOCK_50
// and flags each falling edge of the PS/2 clock
// ------------------------------------------------------------
`timescale 1ns/10ps

module ps2_line_sync (
  input  logic CLOCK_50,
  input  logic reset,
  input  logic i_ps2_clk,
  input  logic i_ps2_dat,
  output logic o_fall,
  output logic o_dat
);

  // Two-flop synchronizers, index 1 is the stable stage
  logic [1:0] clk_sync;
  logic [1:0] dat_sync;

  // Previous synchronized PS/2 clock level
  logic clk_prev;

  // Registered fall pulse
  logic fall_q;

  always_ff @(posedge CLOCK_50) begin
    if (!reset) begin
      // Idle PS/2 lines sit high
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
      fall_q   <= 1'b0;
    end else begin
      clk_sync <= {clk_sync[0], i_ps2_clk};
      dat_sync <= {dat_sync[0], i_ps2_dat};
      clk_prev <= clk_sync[1];
      // High for one cycle on a 1 to 0 change
      fall_q   <= clk_prev & ~clk_sync[1];
    end
  end

  // Fall pulse lands 3 cycles after the PS/2 clock drops
  assign o_fall = fall_q;

  // Data is stable for the whole low half period, so the
  // synchronized level is safe to sample with o_fall
  assign o_dat = dat_sync[1];

endmodule

//--- hw/ps2_frame_rx.sv
// ------------------------------------------------------------
// PS/2 frame receiver: shifts in 11-bit frames, checks start,
// parity and stop, and strobes out each good data byte
// ------------------------------------------------------------
`timescale 1ns/10ps

module ps2_frame_rx (
  input  logic                      CLOCK_50,
  input  logic                      reset,
  input  logic                      i_fall,
  input  logic                      i_dat,
  output ps2_kbd_pkg::byte_strobe_t o_byte
);

  // Bits taken so far in the current frame
  ps2_kbd_pkg::bit_cnt_t bit_cnt_q;

  // Cycles since the last fall while a frame is open
  ps2_kbd_pkg::gap_cnt_t idle_cnt_q;

  // Frame shifter, first bit ends up in bit 0
  logic [ps2_kbd_pkg::FRAME_BITS-1:0] shift_q;

  // Shifter contents including the bit arriving now
  logic [ps2_kbd_pkg::FRAME_BITS-1:0] frame_next;

  // Output byte and strobe
  ps2_kbd_pkg::scan_byte_t data_q;
  logic                    strobe_q;

  // Frame checks
  logic last_bit;
  logic start_ok;
  logic parity_ok;
  logic stop_ok;
  logic idle_expired;

  // LSB first, so new bits enter at the top
  assign frame_next = {i_dat, shift_q[ps2_kbd_pkg::FRAME_BITS-1:1]};

  assign last_bit = (bit_cnt_q == ps2_kbd_pkg::bit_cnt_t'(ps2_kbd_pkg::FRAME_BITS - 1));

  // Start is 0, stop is 1
  assign start_ok = ~frame_next[0];
  assign stop_ok  = frame_next[ps2_kbd_pkg::FRAME_BITS-1];

  // Odd parity over data and parity bit
  assign parity_ok = ^frame_next[9:1];

  assign idle_expired =
    (idle_cnt_q == ps2_kbd_pkg::gap_cnt_t'(ps2_kbd_pkg::FRAME_GAP_CYCLES - 1));

  // Frame shifter carries payload only
  always_ff @(posedge CLOCK_50) begin
    if (i_fall) begin
      shift_q <= frame_next;
    end
  end

  // Data byte register, valid only together with the strobe
  always_ff @(posedge CLOCK_50) begin
    if (i_fall && last_bit) begin
      data_q <= frame_next[8:1];
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (!reset) begin
      bit_cnt_q  <= '0;
      idle_cnt_q <= '0;
      strobe_q   <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      if (i_fall) begin
        idle_cnt_q <= '0;
        if (last_bit) begin
          bit_cnt_q <= '0;
          // Bad frames are dropped silently
          strobe_q  <= start_ok & parity_ok & stop_ok;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else if (bit_cnt_q != '0) begin
        // Partial frame open, watch for a stall
        if (idle_expired) begin
          bit_cnt_q  <= '0;
          idle_cnt_q <= '0;
        end else begin
          idle_cnt_q <= idle_cnt_q + 1'b1;
        end
      end
    end
  end

  assign o_byte = '{valid: strobe_q, data: data_q};

endmodule

//--- hw/scan_code_decoder.sv
// ------------------------------------------------------------
// Scan code decoder: follows the E0 and F0 prefixes and turns
// tracked key codes into press and release events
// ------------------------------------------------------------
`timescale 1ns/10ps

module scan_code_decoder (
  input  logic                      CLOCK_50,
  input  logic                      reset,
  input  ps2_kbd_pkg::byte_strobe_t i_byte,
  output ps2_kbd_pkg::key_event_t   o_event
);

  // Prefix FSM
  ps2_kbd_pkg::prefix_state_t state_q;
  ps2_kbd_pkg::prefix_state_t state_next;

  // Decoded view of the current state
  logic is_ext;
  logic is_break;

  // Table lookup result
  logic                  hit;
  ps2_kbd_pkg::key_idx_t hit_idx;

  // Registered event
  logic                  ev_valid_q;
  ps2_kbd_pkg::key_idx_t ev_key_q;
  logic                  ev_make_q;

  assign is_ext = (state_q == ps2_kbd_pkg::PFX_EXT_MAKE) ||
                  (state_q == ps2_kbd_pkg::PFX_EXT_BREAK);

  assign is_break = (state_q == ps2_kbd_pkg::PFX_BREAK) ||
                    (state_q == ps2_kbd_pkg::PFX_EXT_BREAK);

  // Next prefix state for the incoming byte
  always_comb begin
    case (i_byte.data)
      ps2_kbd_pkg::CODE_EXT: state_next = ps2_kbd_pkg::PFX_EXT_MAKE;
      ps2_kbd_pkg::CODE_BREAK: begin
        // Keep the extended flag across F0
        state_next = is_ext ? ps2_kbd_pkg::PFX_EXT_BREAK : ps2_kbd_pkg::PFX_BREAK;
      end
      // Any other byte closes the sequence
      default: state_next = ps2_kbd_pkg::PFX_MAKE;
    endcase
  end

  // Code table search
  // Arrows only match after E0, letters only without it
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int k = 0; k < ps2_kbd_pkg::NUM_KEYS; k++) begin
      if ((i_byte.data == ps2_kbd_pkg::KEY_CODES[k]) &&
          (ps2_kbd_pkg::KEY_IS_EXT[k] == is_ext)) begin
        hit     = 1'b1;
        hit_idx = ps2_kbd_pkg::key_idx_t'(k);
      end
    end
  end

  // Event payload, qualified by the valid bit
  always_ff @(posedge CLOCK_50) begin
    if (i_byte.valid && hit) begin
      ev_key_q  <= hit_idx;
      ev_make_q <= ~is_break;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (!reset) begin
      state_q    <= ps2_kbd_pkg::PFX_MAKE;
      ev_valid_q <= 1'b0;
    end else begin
      // Prefix bytes never match the table, so no event for them
      ev_valid_q <= i_byte.valid & hit;
      if (i_byte.valid) begin
        state_q <= state_next;
      end
    end
  end

  assign o_event = '{valid: ev_valid_q, key: ev_key_q, make: ev_make_q};

endmodule

//--- hw/key_state_tracker.sv
// ------------------------------------------------------------
// Key state tracker: keeps the pressed bit of every key and
// forms the held vector and the one-cycle press pulses
// ------------------------------------------------------------
`timescale 1ns/10ps

module key_state_tracker (
  input  logic                    CLOCK_50,
  input  logic                    reset,
  input  ps2_kbd_pkg::key_event_t i_event,
  output ps2_kbd_pkg::key_vec_t   o_keys_held,
  output ps2_kbd_pkg::key_vec_t   o_keys_pulse
);

  // Current key state as reported by the keyboard
  ps2_kbd_pkg::key_vec_t pressed_q;

  // Pressed state one cycle late
  ps2_kbd_pkg::key_vec_t lock_q;

  always_ff @(posedge CLOCK_50) begin
    if (!reset) begin
      pressed_q <= '0;
    end else if (i_event.valid) begin
      // Repeated makes write the same value again
      pressed_q[i_event.key] <= i_event.make;
    end
  end

  always_ff @(posedge CLOCK_50) begin
    if (!reset) begin
      lock_q <= '0;
    end else begin
      // Lock rises the cycle after a press and falls
      // the cycle after a release
      lock_q <= pressed_q;
    end
  end

  assign o_keys_held = pressed_q;

  // Only the first cycle of a press has pressed set and lock clear
  assign o_keys_pulse = pressed_q & ~lock_q;

endmodule

//--- hw/ps2_keyboard_top.sv
// ------------------------------------------------------------
// PS/2 keyboard top: line sync, frame receiver, scan code
// decoder and key state tracker in one receive pipeline
// ------------------------------------------------------------
`timescale 1ns/10ps

module ps2_keyboard_top (
  input  logic                  CLOCK_50,
  input  logic                  reset,
  input  logic                  i_ps2_clk,
  input  logic                  i_ps2_dat,
  output ps2_kbd_pkg::key_vec_t o_keys_held,
  output ps2_kbd_pkg::key_vec_t o_keys_pulse
);

  // Line sync to frame receiver
  logic ps2_fall;
  logic ps2_dat;

  // Frame receiver to decoder
  ps2_kbd_pkg::byte_strobe_t rx_byte;

  // Decoder to tracker
  ps2_kbd_pkg::key_event_t key_event;

  ps2_line_sync u_line_sync (
    .CLOCK_50  (CLOCK_50),
    .reset     (reset),
    .i_ps2_clk (i_ps2_clk),
    .i_ps2_dat (i_ps2_dat),
    .o_fall    (ps2_fall),
    .o_dat     (ps2_dat)
  );

  ps2_frame_rx u_frame_rx (
    .CLOCK_50 (CLOCK_50),
    .reset    (reset),
    .i_fall   (ps2_fall),
    .i_dat    (ps2_dat),
    .o_byte   (rx_byte)
  );

  scan_code_decoder u_decoder (
    .CLOCK_50 (CLOCK_50),
    .reset    (reset),
    .i_byte   (rx_byte),
    .o_event  (key_event)
  );

  // Held bit settles 6 cycles after the stop bit fall
  key_state_tracker u_tracker (
    .CLOCK_50     (CLOCK_50),
    .reset        (reset),
    .i_event      (key_event),
    .o_keys_held  (o_keys_held),
    .o_keys_pulse (o_keys_pulse)
  );

endmodule

//--- tb/ps2_keyboard_chk.sv
// ------------------------------------------------------------
// PS/2 keyboard output checker: pulse and reset rules on the
// held and pulse vectors of the top level
// ------------------------------------------------------------
`timescale 1ns/10ps

module ps2_keyboard_chk (
  input logic                  CLOCK_50,
  input logic                  reset,
  input ps2_kbd_pkg::key_vec_t i_keys_held,
  input ps2_kbd_pkg::key_vec_t i_keys_pulse
);

  // Failed assertions so far
  int unsigned err_count = 0;

  // A pulse only on a held key
  a_pulse_held: assert property (@(posedge CLOCK_50) disable iff (!reset)
    (i_keys_pulse & ~i_keys_held) == '0)
  else begin
    $error("pulse bit set while its held bit is clear");
    err_count++;
  end

  // No pulse bit two cycles in a row
  a_pulse_once: assert property (@(posedge CLOCK_50) disable iff (!reset)
    (i_keys_pulse & $past(i_keys_pulse)) == '0)
  else begin
    $error("pulse bit high for more than one cycle");
    err_count++;
  end

  // A rising pulse bit comes with a rising held bit
  a_pulse_rise: assert property (@(posedge CLOCK_50) disable iff (!reset)
    (i_keys_pulse & ~$past(i_keys_pulse) & ~(i_keys_held & ~$past(i_keys_held))) == '0)
  else begin
    $error("pulse bit rose without a press");
    err_count++;
  end

  // Both vectors clear one cycle into reset
  a_reset_clear: assert property (@(posedge CLOCK_50)
    !reset |=> (i_keys_held == '0) && (i_keys_pulse == '0))
  else begin
    $error("outputs not cleared by reset");
    err_count++;
  end

endmodule

bind ps2_keyboard_top ps2_keyboard_chk u_chk (
  .CLOCK_50     (CLOCK_50),
  .reset        (reset),
  .i_keys_held  (o_keys_held),
  .i_keys_pulse (o_keys_pulse)
);

//--- tb/tb_ps2_keyboard.sv
// ------------------------------------------------------------
// PS/2 keyboard testbench with a device model, directed and
// random scan codes, and a scoreboard of held and pulse vectors
// ------------------------------------------------------------
`timescale 1ns/10ps

module tb_ps2_keyboard;

  // Frames in the random phase
  localparam int NUM_RANDOM = 300;

  // Letters take 3 frames, arrows 5, prefix cases 8, typematic 6,
  // bad parity 4, reset 4, then the random frames
  localparam int FRAMES_SENT = 16 * 3 + 4 * 5 + 8 + 6 + 4 + 4 + NUM_RANDOM;

  // Run length in ns from 11 bits of 20 cycles per frame plus slack
  localparam int WATCHDOG_NS = (FRAMES_SENT * 11 * 20 + 2000) * 100;

  logic CLOCK_50 = 1'b0;
  logic reset;
  logic ps2_clk;
  logic ps2_dat;
  ps2_kbd_pkg::key_vec_t keys_held;
  ps2_kbd_pkg::key_vec_t keys_pulse;

  // Scoreboard of the expected held vector and prefix flags
  ps2_kbd_pkg::key_vec_t exp_held;
  logic exp_ext;
  logic exp_brk;
  int unsigned exp_pulses;
  int unsigned pulse_seen = 0;

  int seed;

  ps2_keyboard_top u_dut (
    .CLOCK_50     (CLOCK_50),
    .reset        (reset),
    .i_ps2_clk    (ps2_clk),
    .i_ps2_dat    (ps2_dat),
    .o_keys_held  (keys_held),
    .o_keys_pulse (keys_pulse)
  );

  initial begin
    forever #50 CLOCK_50 = ~CLOCK_50;
  end

  // Count press pulses in the middle of each cycle
  always @(negedge CLOCK_50) begin
    pulse_seen <= pulse_seen + $countones(keys_pulse);
  end

  // Any failed checker assertion ends the run
  always @(negedge CLOCK_50) begin
    if (u_dut.u_chk.err_count != 0) begin
      $display("test failed");
      $fatal(1, "an assertion on the DUT outputs failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("test failed");
    $fatal(1, "timeout, the stimulus did not finish in time");
  end

  // Expected decoder step for one good byte
  task automatic apply_byte(input ps2_kbd_pkg::scan_byte_t b);
    int found;
    found = -1;
    if (b == ps2_kbd_pkg::CODE_EXT) begin
      exp_ext = 1'b1;
      exp_brk = 1'b0;
    end else if (b == ps2_kbd_pkg::CODE_BREAK) begin
      exp_brk = 1'b1;
    end else begin
      // Arrows need E0 and letters must come without it
      for (int k = 0; k < ps2_kbd_pkg::NUM_KEYS; k++) begin
        if (b == ps2_kbd_pkg::KEY_CODES[k] && ps2_kbd_pkg::KEY_IS_EXT[k] == exp_ext) begin
          found = k;
        end
      end
      if (found >= 0) begin
        if (!exp_brk && !exp_held[found]) begin
          exp_pulses++;
        end
        exp_held[found] = ~exp_brk;
      end
      exp_ext = 1'b0;
      exp_brk = 1'b0;
    end
  endtask

  task automatic check_outputs();
    assert (keys_held === exp_held) else begin
      $display("FAIL o_keys_held got %h expected %h", keys_held, exp_held);
      $display("test failed");
      $fatal(1, "held vector mismatch");
    end
    assert (pulse_seen == exp_pulses) else begin
      $display("FAIL o_keys_pulse count got %h expected %h", pulse_seen, exp_pulses);
      $display("test failed");
      $fatal(1, "press pulse count mismatch");
    end
  endtask

  // Device side of one frame with 10 cycles per PS/2 half period
  task automatic send_frame(input ps2_kbd_pkg::scan_byte_t b, input logic bad_parity);
    logic [ps2_kbd_pkg::FRAME_BITS-1:0] frame;
    logic par;
    // Odd parity over data and parity bit
    par = ~^b;
    if (bad_parity) begin
      par = ~par;
    end
    frame = {1'b1, par, b, 1'b0};
    for (int i = 0; i < ps2_kbd_pkg::FRAME_BITS; i++) begin
      ps2_dat = frame[i];
      repeat (10) @(negedge CLOCK_50);
      ps2_clk = 1'b0;
      if (i == ps2_kbd_pkg::FRAME_BITS - 1) begin
        // Held bit settles 6 cycles after the stop bit fall
        repeat (7) @(negedge CLOCK_50);
        if (!bad_parity) begin
          apply_byte(b);
        end
        check_outputs();
        repeat (3) @(negedge CLOCK_50);
      end else begin
        repeat (10) @(negedge CLOCK_50);
      end
      ps2_clk = 1'b1;
    end
  endtask

  task automatic press_key(input int k);
    if (ps2_kbd_pkg::KEY_IS_EXT[k]) begin
      send_frame(ps2_kbd_pkg::CODE_EXT, 1'b0);
    end
    send_frame(ps2_kbd_pkg::KEY_CODES[k], 1'b0);
  endtask

  task automatic release_key(input int k);
    if (ps2_kbd_pkg::KEY_IS_EXT[k]) begin
      send_frame(ps2_kbd_pkg::CODE_EXT, 1'b0);
    end
    send_frame(ps2_kbd_pkg::CODE_BREAK, 1'b0);
    send_frame(ps2_kbd_pkg::KEY_CODES[k], 1'b0);
  endtask

  task automatic apply_reset(input int cycles);
    reset = 1'b0;
    repeat (cycles) @(negedge CLOCK_50);
    reset = 1'b1;
    exp_held = '0;
    exp_ext  = 1'b0;
    exp_brk  = 1'b0;
  endtask

  initial begin
    int pick;
    ps2_kbd_pkg::scan_byte_t rnd_byte;
    reset      = 1'b0;
    ps2_clk    = 1'b1;
    ps2_dat    = 1'b1;
    exp_pulses = 0;
    seed       = 43765;
    apply_reset(5);

    // Every key once as a press and a release
    for (int k = 0; k < ps2_kbd_pkg::NUM_KEYS; k++) begin
      press_key(k);
      release_key(k);
    end

    // Keypad codes without E0 leave the arrows alone
    send_frame(8'h6B, 1'b0);
    send_frame(8'h74, 1'b0);
    send_frame(8'h75, 1'b0);
    send_frame(8'h72, 1'b0);
    // Unknown code after E0 and then a letter code after E0
    send_frame(ps2_kbd_pkg::CODE_EXT, 1'b0);
    send_frame(8'h11, 1'b0);
    send_frame(ps2_kbd_pkg::CODE_EXT, 1'b0);
    send_frame(8'h15, 1'b0);

    // Typematic repeat on A
    press_key(10);
    repeat (3) send_frame(ps2_kbd_pkg::KEY_CODES[10], 1'b0);
    release_key(10);

    // Bad parity W is dropped but the good one after it is not
    send_frame(ps2_kbd_pkg::KEY_CODES[1], 1'b1);
    press_key(1);
    release_key(1);

    // Reset with Q and UP held
    press_key(0);
    press_key(18);
    apply_reset(5);
    check_outputs();
    press_key(0);

    // Random mix of key codes, prefixes and other bytes
    for (int n = 0; n < NUM_RANDOM; n++) begin
      pick = $unsigned($random(seed)) % 8;
      if (pick < 5) begin
        rnd_byte = ps2_kbd_pkg::KEY_CODES[$unsigned($random(seed)) % ps2_kbd_pkg::NUM_KEYS];
      end else if (pick == 5) begin
        rnd_byte = ps2_kbd_pkg::CODE_EXT;
      end else if (pick == 6) begin
        rnd_byte = ps2_kbd_pkg::CODE_BREAK;
      end else begin
        rnd_byte = 8'($random(seed));
      end
      send_frame(rnd_byte, 1'b0);
    end

    repeat (20) @(negedge CLOCK_50);
    check_outputs();
    if (u_dut.u_chk.err_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "an assertion on the DUT outputs failed");
    end
  end

endmodule

//--- project.f
hw/ps2_kbd_pkg.sv
hw/ps2_line_sync.sv
hw/ps2_frame_rx.sv
hw/scan_code_decoder.sv
hw/key_state_tracker.sv
hw/ps2_keyboard_top.sv
tb/ps2_keyboard_chk.sv
tb/tb_ps2_keyboard.sv

//--- run.sh
#!/bin/sh
# Build and run the PS/2 keyboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_ps2_keyboard -f project.f

# Simulation output, kept for the pass search
out=$(./obj_dir/Vtb_ps2_keyboard +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
